/* source/sdram_pkg.sv */
/* SDRAM subsystem shared types
   Address, data and command encodings plus the controller state set */
package sdram_pkg;

	typedef logic [21:0] mem_addr_t;   // Bank 21:20, row 19:8, column 7:1, lane 0
	typedef logic [15:0] mem_word_t;   // One SDRAM data word
	typedef logic [7:0]  mem_byte_t;   // CPU data byte
	typedef logic [11:0] sdram_row_t;  // SDRAM address bus value
	typedef logic [2:0]  sdram_cmd_t;  // {ras_n, cas_n, we_n}

	localparam sdram_cmd_t cmd_nop       = 3'b111;
	localparam sdram_cmd_t cmd_activate  = 3'b011;
	localparam sdram_cmd_t cmd_read      = 3'b101;
	localparam sdram_cmd_t cmd_write     = 3'b100;
	localparam sdram_cmd_t cmd_refresh   = 3'b001;
	localparam sdram_cmd_t cmd_load_mode = 3'b000;

	// CL 2, burst length 1, single-location writes
	localparam sdram_row_t mode_word = 12'b0010_0010_0000;

	typedef enum logic [3:0] {
		st_reset0, st_reset1, st_idle,
		st_ras0, st_ras1,
		st_read0, st_read1, st_read2, st_readv,
		st_write0, st_write1, st_write2,
		st_refresh0, st_refresh1
	} ctrl_state_t;

endpackage

/* source/cpu_apb_port.sv */
/* CPU APB slave port
   Turns one APB byte transfer into a single SDRAM controller request */
`timescale 1ns/1ps

module cpu_apb_port
	import sdram_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  mem_addr_t paddr,
	input  mem_byte_t pwdata,
	output mem_byte_t prdata,
	output logic      pready,
	output logic      cpu_req,
	output logic      cpu_write,
	output mem_addr_t cpu_addr,
	output mem_byte_t cpu_wdata,
	input  mem_byte_t cpu_rdata,
	input  logic      cpu_done
);

	typedef enum logic [1:0] {
		apb_idle,
		apb_wait,
		apb_respond
	} apb_state_t;

	apb_state_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= apb_idle;
		end else begin
			case (state)
				apb_idle:    if (psel && !penable) state <= apb_wait;  // Setup phase
				apb_wait:    if (cpu_done) state <= apb_respond;
				apb_respond: state <= apb_idle;                        // One ready cycle
				default:     state <= apb_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == apb_idle && psel && !penable) begin
			cpu_addr  <= paddr;
			cpu_write <= pwrite;
			cpu_wdata <= pwdata;
		end
		if (state == apb_wait && cpu_done && !cpu_write)
			prdata <= cpu_rdata;  // Hold read byte for the ready cycle
	end

	// Level request that drops the cycle after done
	assign cpu_req = (state == apb_wait);
	assign pready  = (state == apb_respond);

endmodule

/* source/video_fetch.sv */
/* Video line fetcher
   Reads a run of word pairs from the line base and hands each pair to the display */
`timescale 1ns/1ps

module video_fetch
	import sdram_pkg::*;
#(
	parameter int VID_PAIRS = 4
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      line_start,
	input  mem_addr_t line_base,
	output logic      vid_req,
	output mem_addr_t vid_addr,
	input  mem_word_t vid_data0,
	input  mem_word_t vid_data1,
	input  logic      vid_done,
	output logic      pix_valid,
	output mem_word_t pix_word0,
	output mem_word_t pix_word1,
	output logic      line_busy
);

	localparam int CW = $clog2(VID_PAIRS + 1);

	logic [CW-1:0] pairs_left;

	always_ff @(posedge clk) begin
		if (reset) begin
			vid_req    <= 1'b0;
			pix_valid  <= 1'b0;
			line_busy  <= 1'b0;
			pairs_left <= '0;
		end else begin
			pix_valid <= vid_done;
			if (line_start && !line_busy) begin  // Pulses while busy are dropped
				line_busy  <= 1'b1;
				vid_req    <= 1'b1;
				pairs_left <= CW'(VID_PAIRS);
			end else if (vid_done) begin
				vid_req    <= 1'b0;
				pairs_left <= pairs_left - 1'b1;
			end else if (pix_valid) begin
				if (pairs_left != '0)
					vid_req <= 1'b1;  // Next pair
				else
					line_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (line_start && !line_busy)
			vid_addr <= {line_base[21:2], 2'b00};  // Pair aligned
		else if (vid_done)
			vid_addr <= vid_addr + mem_addr_t'(4);
		if (vid_done) begin
			pix_word0 <= vid_data0;
			pix_word1 <= vid_data1;
		end
	end

endmodule

/* source/sdram_controller.sv */
/* SDRAM controller
   Arbitrates video, CPU and refresh, then runs a fixed activate and
   auto-precharge column sequence on a single CL2 SDRAM */
`timescale 1ns/1ps

module sdram_controller
	import sdram_pkg::*;
#(
	parameter int REFRESH_CYCLES = 400
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       cpu_req,
	input  logic       cpu_write,
	input  mem_addr_t  cpu_addr,
	input  mem_byte_t  cpu_wdata,
	output mem_byte_t  cpu_rdata,
	output logic       cpu_done,
	input  logic       vid_req,
	input  mem_addr_t  vid_addr,
	output mem_word_t  vid_data0,
	output mem_word_t  vid_data1,
	output logic       vid_done,
	inout  wire [15:0] dq,
	output sdram_row_t sd_addr,
	output logic [1:0] sd_ba,
	output logic       sd_ras_n,
	output logic       sd_cas_n,
	output logic       sd_we_n,
	output logic       sd_ldqm,
	output logic       sd_udqm
);

	localparam int RW = $clog2(REFRESH_CYCLES + 1);

	ctrl_state_t state;
	sdram_cmd_t  cmd;
	mem_addr_t   acc_addr;
	mem_byte_t   acc_wdata;
	mem_word_t   rd_word0;
	logic        is_vid;
	logic        is_write;
	logic [RW-1:0] refresh_count;
	logic        refresh_due;

	assign refresh_due = (refresh_count >= RW'(REFRESH_CYCLES));

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= st_reset0;
			is_vid        <= 1'b0;
			is_write      <= 1'b0;
			refresh_count <= '0;
		end else begin
			if (state == st_refresh0)
				refresh_count <= '0;
			else if (!refresh_due)
				refresh_count <= refresh_count + 1'b1;
			case (state)
				st_reset0: state <= st_reset1;
				st_reset1: state <= st_idle;
				st_idle: begin
					if (refresh_due) begin
						state <= st_refresh0;
					end else if (vid_req) begin  // Video wins over CPU
						state    <= st_ras0;
						is_vid   <= 1'b1;
						is_write <= 1'b0;
					end else if (cpu_req) begin
						state    <= st_ras0;
						is_vid   <= 1'b0;
						is_write <= cpu_write;
					end
				end
				st_ras0:     state <= st_ras1;
				st_ras1:     state <= (is_write && !is_vid) ? st_write0 : st_read0;
				st_read0:    state <= st_read1;
				st_read1:    state <= st_read2;
				st_read2:    state <= is_vid ? st_readv : st_idle;
				st_readv:    state <= st_refresh0;  // Refresh after every burst
				st_write0:   state <= st_write1;
				st_write1:   state <= st_write2;
				st_write2:   state <= st_idle;
				st_refresh0: state <= st_refresh1;
				st_refresh1: state <= st_idle;
				default:     state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && !refresh_due) begin
			if (vid_req) begin
				acc_addr <= vid_addr;
			end else if (cpu_req) begin
				acc_addr  <= cpu_addr;
				acc_wdata <= cpu_wdata;
			end
		end
		if (state == st_read2 && is_vid)
			rd_word0 <= dq;  // First word of the pair
	end

	always_comb begin
		cmd     = cmd_nop;
		sd_addr = '0;
		sd_ba   = acc_addr[21:20];
		sd_ldqm = 1'b0;
		sd_udqm = 1'b0;
		case (state)
			st_reset0: begin
				cmd     = cmd_load_mode;
				sd_addr = mode_word;
				sd_ba   = 2'b00;
			end
			st_ras0: begin
				cmd     = cmd_activate;
				sd_addr = acc_addr[19:8];
			end
			st_read0: begin
				// Video keeps the row open for its second column
				cmd     = cmd_read;
				sd_addr = {1'b0, !is_vid, 3'b000, acc_addr[7:1]};
			end
			st_read1: begin
				if (is_vid) begin
					cmd     = cmd_read;
					sd_addr = {1'b0, 1'b1, 3'b000, acc_addr[7:2], 1'b1};
				end
			end
			st_write0: begin
				cmd     = cmd_write;
				sd_addr = {1'b0, 1'b1, 3'b000, acc_addr[7:1]};
				sd_ldqm = acc_addr[0];   // Mask the lane not written
				sd_udqm = !acc_addr[0];
			end
			st_refresh0: cmd = cmd_refresh;
			default: cmd = cmd_nop;
		endcase
	end

	assign {sd_ras_n, sd_cas_n, sd_we_n} = cmd;

	// Same byte on both lanes with the mask picking one
	assign dq = (state == st_write0) ? {acc_wdata, acc_wdata} : 16'bz;

	assign cpu_rdata = acc_addr[0] ? dq[15:8] : dq[7:0];
	assign cpu_done  = (state == st_read2 && !is_vid) || (state == st_write2);
	assign vid_data0 = rd_word0;
	assign vid_data1 = dq;  // Second word is on the bus in readv
	assign vid_done  = (state == st_readv);

endmodule

/* source/memory_subsystem.sv */
/* Memory subsystem top level
   Joins the CPU APB port and the video fetcher onto one SDRAM controller */
`timescale 1ns/1ps

module memory_subsystem
	import sdram_pkg::*;
#(
	parameter int REFRESH_CYCLES = 400,
	parameter int VID_PAIRS      = 4
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       psel,
	input  logic       penable,
	input  logic       pwrite,
	input  mem_addr_t  paddr,
	input  mem_byte_t  pwdata,
	output mem_byte_t  prdata,
	output logic       pready,
	input  logic       line_start,
	input  mem_addr_t  line_base,
	output logic       pix_valid,
	output mem_word_t  pix_word0,
	output mem_word_t  pix_word1,
	output logic       line_busy,
	inout  wire [15:0] dq,
	output sdram_row_t sd_addr,
	output logic [1:0] sd_ba,
	output logic       sd_ras_n,
	output logic       sd_cas_n,
	output logic       sd_we_n,
	output logic       sd_ldqm,
	output logic       sd_udqm
);

	logic      cpu_req, cpu_write, cpu_done;
	mem_addr_t cpu_addr;
	mem_byte_t cpu_wdata, cpu_rdata;
	logic      vid_req, vid_done;
	mem_addr_t vid_addr;
	mem_word_t vid_data0, vid_data1;

	cpu_apb_port i_cpu_apb_port (
		.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
		.cpu_req, .cpu_write, .cpu_addr, .cpu_wdata, .cpu_rdata, .cpu_done
	);

	video_fetch #(.VID_PAIRS(VID_PAIRS)) i_video_fetch (
		.clk, .reset, .line_start, .line_base, .vid_req, .vid_addr,
		.vid_data0, .vid_data1, .vid_done, .pix_valid, .pix_word0, .pix_word1, .line_busy
	);

	sdram_controller #(.REFRESH_CYCLES(REFRESH_CYCLES)) i_sdram_controller (
		.clk, .reset,
		.cpu_req, .cpu_write, .cpu_addr, .cpu_wdata, .cpu_rdata, .cpu_done,
		.vid_req, .vid_addr, .vid_data0, .vid_data1, .vid_done,
		.dq, .sd_addr, .sd_ba, .sd_ras_n, .sd_cas_n, .sd_we_n, .sd_ldqm, .sd_udqm
	);

endmodule

/* tests/sdram_model.sv */
/* Behavioural SDRAM model
   Four banks, CAS latency two, byte masks and auto-precharge */
`timescale 1ns/1ps

module sdram_model (
	input  logic        clk,
	inout  wire  [15:0] dq,
	input  logic [11:0] sd_addr,
	input  logic [1:0]  sd_ba,
	input  logic        sd_ras_n,
	input  logic        sd_cas_n,
	input  logic        sd_we_n,
	input  logic        sd_ldqm,
	input  logic        sd_udqm,
	output logic        mode_cl2_first,
	output logic [15:0] refresh_count,
	output logic [15:0] bad_access_count
);

	// Standard SDRAM command truth table on {ras_n, cas_n, we_n}
	localparam logic [2:0] CMD_NOP   = 3'b111;
	localparam logic [2:0] CMD_ACT   = 3'b011;
	localparam logic [2:0] CMD_READ  = 3'b101;
	localparam logic [2:0] CMD_WRITE = 3'b100;
	localparam logic [2:0] CMD_REF   = 3'b001;
	localparam logic [2:0] CMD_MODE  = 3'b000;

	logic [15:0] mem [int];
	logic [11:0] open_row [4];
	logic [3:0]  row_active = 4'b0000;
	logic [15:0] stage1 = '0;
	logic [15:0] stage2 = '0;
	logic        valid1 = 1'b0;
	logic        valid2 = 1'b0;
	logic        first_seen = 1'b0;
	logic        first_ok = 1'b0;
	logic [15:0] refreshes = '0;
	logic [15:0] bad = '0;
	logic [2:0]  cmd;
	logic [20:0] widx;

	assign cmd  = {sd_ras_n, sd_cas_n, sd_we_n};
	assign widx = {sd_ba, open_row[sd_ba], sd_addr[6:0]};  // Bank, row, column
	assign dq   = valid2 ? stage2 : 16'bz;                 // Second cycle after READ

	assign mode_cl2_first   = first_ok;
	assign refresh_count    = refreshes;
	assign bad_access_count = bad;

	// Untouched locations return a pattern of their whole word address
	function automatic logic [15:0] read_word(input logic [20:0] w);
		if (mem.exists(int'(w)))
			return mem[int'(w)];
		return w[15:0] ^ {11'h000, w[20:16]} ^ 16'ha5c3;
	endfunction

	// Masked lanes keep the stored byte
	function automatic logic [15:0] masked_write(input logic [20:0] w, input logic [15:0] d,
			input logic lo_mask, input logic hi_mask);
		logic [15:0] old;
		old = read_word(w);
		return {hi_mask ? old[15:8] : d[15:8], lo_mask ? old[7:0] : d[7:0]};
	endfunction

	always @(posedge clk) begin
		valid2 <= valid1;
		stage2 <= stage1;
		valid1 <= 1'b0;
		if (cmd != CMD_NOP) begin
			if (!first_seen) begin
				first_seen <= 1'b1;
				first_ok   <= (cmd == CMD_MODE) && (sd_addr[6:4] == 3'd2);  // CL field
			end
			case (cmd)
				CMD_ACT: begin
					if (row_active[sd_ba])
						bad <= bad + 16'd1;  // Bank already open
					open_row[sd_ba]   <= sd_addr;
					row_active[sd_ba] <= 1'b1;
				end
				CMD_READ: begin
					if (!row_active[sd_ba])
						bad <= bad + 16'd1;
					stage1 <= read_word(widx);
					valid1 <= 1'b1;
					if (sd_addr[10])
						row_active[sd_ba] <= 1'b0;  // Auto-precharge
				end
				CMD_WRITE: begin
					if (!row_active[sd_ba])
						bad <= bad + 16'd1;
					mem[int'(widx)] = masked_write(widx, dq, sd_ldqm, sd_udqm);
					if (sd_addr[10])
						row_active[sd_ba] <= 1'b0;
				end
				CMD_REF: begin
					if (row_active != 4'b0000)
						bad <= bad + 16'd1;  // Refresh needs all banks closed
					refreshes <= refreshes + 16'd1;
				end
				default: ;
			endcase
		end
	end

endmodule

/* tests/tb_memory_subsystem.sv */
/* Memory subsystem testbench
   Applies a table of APB and line fetch operations against a behavioural SDRAM */
`timescale 1ns/1ps

module tb_memory_subsystem;
	import sdram_pkg::*;

	localparam int REFRESH_CYCLES = 40;
	localparam int VID_PAIRS      = 4;
	localparam mem_addr_t LINE_BASE = 22'h12a440;  // Bank 1, pair aligned

	typedef enum logic [2:0] {op_write, op_read, op_fetch, op_fetch_read, op_idle} op_t;
	typedef struct packed {
		op_t       op;
		mem_addr_t addr;
		mem_byte_t data;
		mem_byte_t expected;
	} entry_t;

	logic       clk = 1'b0;
	logic       reset;
	logic       psel;
	logic       penable;
	logic       pwrite;
	mem_addr_t  paddr;
	mem_byte_t  pwdata;
	mem_byte_t  prdata;
	logic       pready;
	logic       line_start;
	mem_addr_t  line_base;
	logic       pix_valid;
	mem_word_t  pix_word0;
	mem_word_t  pix_word1;
	logic       line_busy;
	wire [15:0] dq;
	sdram_row_t sd_addr;
	logic [1:0] sd_ba;
	logic       sd_ras_n;
	logic       sd_cas_n;
	logic       sd_we_n;
	logic       sd_ldqm;
	logic       sd_udqm;
	logic       mode_cl2_first;
	logic [15:0] refresh_count;
	logic [15:0] bad_access_count;

	entry_t    stim[$];
	mem_byte_t ref_mem [int];
	mem_byte_t rd_byte;
	int        latency;
	int        quiet_latency = 0;
	int        refreshes_before;
	int        cur_entry = 0;
	int        errors = 0;
	int        checks = 0;
	int        cycles = 0;
	int        cycle_limit = 1000;

	memory_subsystem #(.REFRESH_CYCLES(REFRESH_CYCLES), .VID_PAIRS(VID_PAIRS)) i_memory_subsystem (
		.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
		.line_start, .line_base, .pix_valid, .pix_word0, .pix_word1, .line_busy,
		.dq, .sd_addr, .sd_ba, .sd_ras_n, .sd_cas_n, .sd_we_n, .sd_ldqm, .sd_udqm
	);

	sdram_model i_sdram_model (
		.clk, .dq, .sd_addr, .sd_ba, .sd_ras_n, .sd_cas_n, .sd_we_n, .sd_ldqm, .sd_udqm,
		.mode_cl2_first, .refresh_count, .bad_access_count
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the table did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	function automatic mem_word_t ref_word(input mem_addr_t a);
		return {ref_mem[int'(a) + 1], ref_mem[int'(a)]};  // Low byte at the even address
	endfunction

	// Pairs of banks share a row and column so that only the bank bits tell them apart
	// Bank 0 matches 22'h000100 in everything but the row
	function automatic mem_addr_t bank_addr(input int b);
		return {2'(b), (b < 2) ? 12'h0a5 : 12'h35a, 7'h00, 1'b0};
	endfunction

	function automatic void add_entry(input op_t op, input mem_addr_t addr);
		entry_t e;
		e.op       = op;
		e.addr     = addr;
		e.data     = 8'h00;
		e.expected = 8'h00;
		if (op == op_write) begin
			e.data              = 8'($urandom);
			e.expected          = e.data;
			ref_mem[int'(addr)] = e.data;
		end else if (op == op_read) begin
			e.expected = ref_mem[int'(addr)];
		end else if (op == op_fetch_read) begin
			e.expected = ref_mem[int'(addr) + 1];  // Byte read during the fetch
		end
		stim.push_back(e);
	endfunction

	task automatic build_table();
		add_entry(op_write, 22'h000100);
		add_entry(op_write, 22'h000101);
		add_entry(op_read, 22'h000100);
		add_entry(op_read, 22'h000101);
		for (int b = 0; b < 4; b++) begin
			add_entry(op_write, bank_addr(b));
		end
		for (int b = 0; b < 4; b++) begin
			add_entry(op_read, bank_addr(b));
		end
		for (int i = 0; i < 4 * VID_PAIRS; i++) begin
			add_entry(op_write, LINE_BASE + mem_addr_t'(i));
		end
		add_entry(op_fetch, LINE_BASE);
		add_entry(op_fetch_read, LINE_BASE);
		add_entry(op_idle, '0);
		add_entry(op_read, 22'h000100);
		add_entry(op_read, 22'h000101);
		add_entry(op_read, bank_addr(0));
		add_entry(op_read, bank_addr(3));
	endtask

	task automatic apb_access(input logic write, input mem_addr_t addr, input mem_byte_t wdata,
			output mem_byte_t rdata, output int wait_cycles);
		@(posedge clk);
		#1;
		psel        = 1'b1;  // Setup phase
		penable     = 1'b0;
		pwrite      = write;
		paddr       = addr;
		pwdata      = wdata;
		wait_cycles = 0;
		@(posedge clk);
		#1;
		penable = 1'b1;
		while (!pready) begin
			@(posedge clk);
			#1;
			wait_cycles++;
		end
		rdata = prdata;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic line_fetch(input mem_addr_t base);
		int pairs;
		mem_addr_t a;
		pairs = 0;
		@(posedge clk);
		#1;
		line_start = 1'b1;
		line_base  = base;
		@(posedge clk);
		#1;
		line_start = 1'b0;
		while (line_busy) begin
			if (pix_valid) begin
				a = base + mem_addr_t'(4 * pairs);
				check($sformatf("entry %0d pair %0d word0", cur_entry, pairs),
					32'(ref_word(a)), 32'(pix_word0));
				check($sformatf("entry %0d pair %0d word1", cur_entry, pairs),
					32'(ref_word(a + mem_addr_t'(2))), 32'(pix_word1));
				pairs++;
			end
			@(posedge clk);
			#1;
		end
		check($sformatf("entry %0d pix_valid count", cur_entry), 32'(VID_PAIRS), 32'(pairs));
	endtask

	initial begin
		reset      = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		line_start = 1'b0;
		line_base  = '0;
		void'($urandom(24));
		build_table();
		cycle_limit = stim.size() * 200 + 5;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		check("pready after reset", 32'(0), 32'(pready));
		check("pix_valid after reset", 32'(0), 32'(pix_valid));
		check("line_busy after reset", 32'(0), 32'(line_busy));
		check("first command load mode CL2", 32'(1), 32'(mode_cl2_first));
		foreach (stim[i]) begin
			cur_entry = i;
			case (stim[i].op)
				op_write: apb_access(1'b1, stim[i].addr, stim[i].data, rd_byte, latency);
				op_read: begin
					apb_access(1'b0, stim[i].addr, 8'h00, rd_byte, latency);
					if (quiet_latency == 0)
						quiet_latency = latency;  // First read runs with no video load
					check($sformatf("entry %0d read %h", i, stim[i].addr),
						32'(stim[i].expected), 32'(rd_byte));
				end
				op_fetch: line_fetch(stim[i].addr);
				op_fetch_read: begin
					fork
						line_fetch(stim[i].addr);
						begin
							repeat (2) @(posedge clk);
							apb_access(1'b0, stim[i].addr + mem_addr_t'(1), 8'h00,
								rd_byte, latency);
							check($sformatf("entry %0d read during fetch", i),
								32'(stim[i].expected), 32'(rd_byte));
							check($sformatf("entry %0d pready delayed by video", i),
								32'(1), 32'(latency > quiet_latency + 8));
						end
					join
				end
				op_idle: begin
					refreshes_before = int'(refresh_count);
					repeat (2 * REFRESH_CYCLES) @(posedge clk);
					#1;
					check($sformatf("entry %0d refresh while idle", i),
						32'(1), 32'(int'(refresh_count) > refreshes_before));
				end
				default: ;
			endcase
		end
		check("SDRAM protocol violations", 32'(0), 32'(bad_access_count));
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* compile.f */
source/sdram_pkg.sv
source/cpu_apb_port.sv
source/video_fetch.sv
source/sdram_controller.sv
source/memory_subsystem.sv
tests/sdram_model.sv
tests/tb_memory_subsystem.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_memory_subsystem
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
